//--- design/dll_rx_top.sv
`timescale 1ns/1ns
`default_nettype none

module dll_rx_top
  import pcie_dll_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             phy_link_up_i,
  input  dll_stream_t      rx_i,
  input  logic             tlp_sent_i,
  input  fc_req_t          fc_req_i,
  output logic             rx_ready_o,
  output logic             crc_err_o,
  output logic             fc1_done_o,
  output logic             fc2_done_o,
  output fc_limits_t       fc_limits_o,
  output logic [SEQ_W-1:0] next_seq_o,
  output logic [SEQ_W-1:0] ackd_seq_o,
  output logic [SEQ_W-1:0] outstanding_o,
  output logic             nak_replay_o,
  output logic             fc_grant_o
);

  seq_report_t seq_rep;

  dllp_rx_handler u_handler (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .phy_link_up_i (phy_link_up_i),
    .rx_i          (rx_i),
    .rx_ready_o    (rx_ready_o),
    .crc_err_o     (crc_err_o),
    .seq_rep_o     (seq_rep),
    .fc_limits_o   (fc_limits_o),
    .fc1_done_o    (fc1_done_o),
    .fc2_done_o    (fc2_done_o)
  );

  replay_seq_tracker u_tracker (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .seq_rep_i     (seq_rep),
    .tlp_sent_i    (tlp_sent_i),
    .next_seq_o    (next_seq_o),
    .ackd_seq_o    (ackd_seq_o),
    .outstanding_o (outstanding_o),
    .nak_replay_o  (nak_replay_o)
  );

  // gate stays closed until all InitFC2 DLLPs are in
  fc_credit_gate u_gate (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .limits_i   (fc_limits_o),
    .fc_ready_i (fc2_done_o),
    .req_i      (fc_req_i),
    .grant_o    (fc_grant_o)
  );

endmodule

`default_nettype wire

//--- design/dllp_crc16.sv
`timescale 1ns/1ns
`default_nettype none

module dllp_crc16
  import pcie_dll_pkg::*;
(
  input  logic [DLLP_W-1:0] data_i,
  output logic [15:0]       crc_o
);

  logic [15:0] crc_c;

  // one bit of the serial LFSR
  function automatic logic [15:0] crc_step(
    input logic [15:0] crc,
    input logic        din
  );
    logic        fb;
    logic [15:0] nxt;
    fb  = crc[15] ^ din;
    nxt = {crc[14:0], 1'b0};
    if (fb) begin
      nxt = nxt ^ CRC_POLY;
    end
    return nxt;
  endfunction

  // msb first over the whole body
  always_comb begin
    crc_c = CRC_SEED;
    for (int i = DLLP_W - 1; i >= 0; i--) begin
      crc_c = crc_step(crc_c, data_i[i]);
    end
  end

  assign crc_o = ~crc_c;

endmodule

`default_nettype wire

//--- design/dllp_rx_handler.sv
`timescale 1ns/1ns
`default_nettype none

module dllp_rx_handler
  import pcie_dll_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        phy_link_up_i,
  input  dll_stream_t rx_i,
  output logic        rx_ready_o,
  output logic        crc_err_o,
  output seq_report_t seq_rep_o,
  output fc_limits_t  fc_limits_o,
  output logic        fc1_done_o,
  output logic        fc2_done_o
);

  typedef enum logic [1:0] {
    IDLE,
    CHECK_CRC,
    PROCESS
  } state_e;

  state_e      state_q, state_d;
  dllp_union_t dllp_q;
  logic [15:0] crc_q;
  logic [15:0] crc_calc;
  fc_limits_t  lim_q, lim_d;
  // bit 0 posted, bit 1 non-posted, bit 2 completion
  logic [2:0]  fc1_q, fc1_d;
  logic [2:0]  fc2_q, fc2_d;
  logic        beat;
  logic        load_p;
  logic        load_np;
  logic [7:0]  type_masked;

  // held low while in reset
  assign rx_ready_o  = ~rst_i &
                       ((state_q == IDLE) ? phy_link_up_i : (state_q == CHECK_CRC));
  assign beat        = rx_i.tvalid & rx_ready_o;
  assign type_masked = {dllp_q.ack_nack.dllp_type[7:3], 3'b000};

  dllp_crc16 u_crc (
    .data_i (rx_i.tdata),
    .crc_o  (crc_calc)
  );

  // body and its crc taken on the first beat
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && beat) begin
      dllp_q <= rx_i.tdata;
      crc_q  <= crc_calc;
    end
  end

  always_comb begin
    state_d   = state_q;
    crc_err_o = 1'b0;
    seq_rep_o = '0;
    lim_d     = lim_q;
    fc1_d     = fc1_q;
    fc2_d     = fc2_q;
    load_p    = 1'b0;
    load_np   = 1'b0;

    case (state_q)
      IDLE: begin
        if (beat) begin
          state_d = CHECK_CRC;
        end
      end
      CHECK_CRC: begin
        if (beat) begin
          if (rx_i.tdata[15:0] == crc_q) begin
            state_d = PROCESS;
          end else begin
            crc_err_o = 1'b1;
            state_d   = IDLE;
          end
        end
      end
      PROCESS: begin
        case (type_masked)
          ACK, NAK: begin
            seq_rep_o.vld    = 1'b1;
            seq_rep_o.is_ack = (type_masked == ACK);
            seq_rep_o.seq    = get_seq(dllp_q.ack_nack);
          end
          INITFC1_P: begin
            load_p   = 1'b1;
            fc1_d[0] = 1'b1;
          end
          INITFC1_NP: begin
            load_np  = 1'b1;
            fc1_d[1] = 1'b1;
          end
          INITFC1_CPL: fc1_d[2] = 1'b1;
          INITFC2_P: begin
            load_p   = 1'b1;
            fc2_d[0] = 1'b1;
          end
          INITFC2_NP: begin
            load_np  = 1'b1;
            fc2_d[1] = 1'b1;
          end
          INITFC2_CPL: fc2_d[2] = 1'b1;
          UPDATEFC_P:  load_p  = 1'b1;
          UPDATEFC_NP: load_np = 1'b1;
          // power management, vendor and completion updates
          default: begin
          end
        endcase

        if (load_p) begin
          lim_d.ph = get_fc_hdr(dllp_q.fc);
          lim_d.pd = get_fc_data(dllp_q.fc);
        end
        if (load_np) begin
          lim_d.nph = get_fc_hdr(dllp_q.fc);
          lim_d.npd = get_fc_data(dllp_q.fc);
        end
        state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      lim_q   <= '0;
      fc1_q   <= '0;
      fc2_q   <= '0;
    end else begin
      state_q <= state_d;
      lim_q   <= lim_d;
      fc1_q   <= fc1_d;
      fc2_q   <= fc2_d;
    end
  end

  assign fc_limits_o = lim_q;
  assign fc1_done_o  = &fc1_q;
  assign fc2_done_o  = &fc2_q;

endmodule

`default_nettype wire

//--- design/fc_credit_gate.sv
`timescale 1ns/1ns
`default_nettype none

module fc_credit_gate
  import pcie_dll_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  fc_limits_t limits_i,
  input  logic       fc_ready_i,
  input  fc_req_t    req_i,
  output logic       grant_o
);

  logic [HDR_FC_W-1:0]  p_hdr_q, np_hdr_q;
  logic [DATA_FC_W-1:0] p_data_q, np_data_q;

  logic [HDR_FC_W-1:0]  lim_h, used_h, hdr_room;
  logic [DATA_FC_W-1:0] lim_d, used_d, data_room;
  logic                 hdr_ok;
  logic                 data_ok;

  // pick the counters of the requested class
  always_comb begin
    if (req_i.posted) begin
      lim_h  = limits_i.ph;
      lim_d  = limits_i.pd;
      used_h = p_hdr_q;
      used_d = p_data_q;
    end else begin
      lim_h  = limits_i.nph;
      lim_d  = limits_i.npd;
      used_h = np_hdr_q;
      used_d = np_data_q;
    end
  end

  // modulo compare, results wrap at the field width
  assign hdr_room  = lim_h - used_h - 1'b1;
  assign data_room = lim_d - used_d - req_i.data_cred;
  assign hdr_ok    = (hdr_room <= HDR_FC_LIM);
  assign data_ok   = (data_room <= DATA_FC_LIM);

  assign grant_o = req_i.vld & fc_ready_i & hdr_ok & data_ok;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      p_hdr_q   <= '0;
      p_data_q  <= '0;
      np_hdr_q  <= '0;
      np_data_q <= '0;
    end else if (grant_o) begin
      if (req_i.posted) begin
        p_hdr_q  <= p_hdr_q + 1'b1;
        p_data_q <= p_data_q + req_i.data_cred;
      end else begin
        np_hdr_q  <= np_hdr_q + 1'b1;
        np_data_q <= np_data_q + req_i.data_cred;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/pcie_dll_pkg.sv
`default_nettype none

package pcie_dll_pkg;

  localparam int SEQ_W     = 12;
  localparam int HDR_FC_W  = 8;
  localparam int DATA_FC_W = 12;
  localparam int DLLP_W    = 32;

  // credit windows, half the counter range
  localparam int HDR_FC_LIM  = 2 ** (HDR_FC_W - 1);
  localparam int DATA_FC_LIM = 2 ** (DATA_FC_W - 1);

  localparam logic [15:0] CRC_SEED = 16'hFFFF;
  localparam logic [15:0] CRC_POLY = 16'h100B;

  // low 3 bits carry the VC and are masked before decode
  typedef enum logic [7:0] {
    ACK          = 8'h00,
    NAK          = 8'h10,
    INITFC1_P    = 8'h40,
    INITFC1_NP   = 8'h50,
    INITFC1_CPL  = 8'h60,
    UPDATEFC_P   = 8'h80,
    UPDATEFC_NP  = 8'h90,
    UPDATEFC_CPL = 8'hA0,
    INITFC2_P    = 8'hC0,
    INITFC2_NP   = 8'hD0,
    INITFC2_CPL  = 8'hE0
  } dllp_type_e;

  typedef struct packed {
    logic [7:0]       dllp_type;
    logic [11:0]      rsvd;
    logic [SEQ_W-1:0] seq;
  } ack_nack_t;

  typedef struct packed {
    logic [7:0]           dllp_type;
    logic [1:0]           rsvd0;
    logic [HDR_FC_W-1:0]  hdr_fc;
    logic [1:0]           rsvd1;
    logic [DATA_FC_W-1:0] data_fc;
  } fc_dllp_t;

  // one body word, two views
  typedef union packed {
    ack_nack_t ack_nack;
    fc_dllp_t  fc;
  } dllp_union_t;

  typedef struct packed {
    logic [DLLP_W-1:0] tdata;
    logic              tvalid;
  } dll_stream_t;

  typedef struct packed {
    logic [HDR_FC_W-1:0]  ph;
    logic [DATA_FC_W-1:0] pd;
    logic [HDR_FC_W-1:0]  nph;
    logic [DATA_FC_W-1:0] npd;
  } fc_limits_t;

  typedef struct packed {
    logic             vld;
    logic             is_ack;
    logic [SEQ_W-1:0] seq;
  } seq_report_t;

  // each request also costs one header credit
  typedef struct packed {
    logic                 vld;
    logic                 posted;
    logic [DATA_FC_W-1:0] data_cred;
  } fc_req_t;

  function automatic logic [HDR_FC_W-1:0] get_fc_hdr(input fc_dllp_t dllp);
    return dllp.hdr_fc;
  endfunction

  function automatic logic [DATA_FC_W-1:0] get_fc_data(input fc_dllp_t dllp);
    return dllp.data_fc;
  endfunction

  function automatic logic [SEQ_W-1:0] get_seq(input ack_nack_t dllp);
    return dllp.seq;
  endfunction

endpackage

`default_nettype wire

//--- design/replay_seq_tracker.sv
`timescale 1ns/1ns
`default_nettype none

module replay_seq_tracker
  import pcie_dll_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_i,
  input  seq_report_t      seq_rep_i,
  input  logic             tlp_sent_i,
  output logic [SEQ_W-1:0] next_seq_o,
  output logic [SEQ_W-1:0] ackd_seq_o,
  output logic [SEQ_W-1:0] outstanding_o,
  output logic             nak_replay_o
);

  logic [SEQ_W-1:0] next_seq_q;
  logic [SEQ_W-1:0] ackd_seq_q;
  logic             nak_q;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      next_seq_q <= '0;
      // one behind next_seq, nothing in flight
      ackd_seq_q <= '1;
      nak_q      <= 1'b0;
    end else begin
      if (tlp_sent_i) begin
        next_seq_q <= next_seq_q + 1'b1;
      end
      if (seq_rep_i.vld) begin
        ackd_seq_q <= seq_rep_i.seq;
      end
      nak_q <= seq_rep_i.vld & ~seq_rep_i.is_ack;
    end
  end

  // wraps modulo 4096 through the counter width
  assign outstanding_o = next_seq_q - 1'b1 - ackd_seq_q;

  assign next_seq_o   = next_seq_q;
  assign ackd_seq_o   = ackd_seq_q;
  assign nak_replay_o = nak_q;

endmodule

`default_nettype wire

//--- dv/dll_rx_tb.sv
`timescale 1ns/1ns
`default_nettype none

module dll_rx_tb
  import pcie_dll_pkg::*;
();

  typedef enum logic [1:0] {OP_DLLP, OP_SENT, OP_REQ, OP_LINK} op_e;

  // exp is crc_err_o for a DLLP and fc_grant_o for a request
  typedef struct packed {
    op_e         op;
    logic [31:0] body;
    logic        corrupt;
    fc_req_t     req;
    logic        exp;
  } entry_t;

  logic clk_i, rst_i, phy_link_up_i, tlp_sent_i;
  dll_stream_t rx_i;
  fc_req_t fc_req_i;
  logic rx_ready_o, crc_err_o, fc1_done_o, fc2_done_o, nak_replay_o, fc_grant_o;
  fc_limits_t fc_limits_o;
  logic [SEQ_W-1:0] next_seq_o, ackd_seq_o, outstanding_o;

  entry_t tbl[$];
  int unsigned seed;
  int cycles = 0;
  int cycle_limit = 1000;

  // reference model
  fc_limits_t m_lim;
  logic [2:0] m_fc1, m_fc2;
  logic [SEQ_W-1:0] m_next, m_ackd;
  logic [7:0] m_ph, m_nph;
  logic [11:0] m_pd, m_npd;
  logic m_nak;

  dll_rx_top DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("run timed out after %0d cycles", cycles);
      abort_run();
    end
  end

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_seq(input string name, input logic [SEQ_W-1:0] exp,
                           input logic [SEQ_W-1:0] act);
    if (act !== exp) begin
      $display("Mismatch at %0t: %s expected %0d got %0d", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_limits(input fc_limits_t exp, input fc_limits_t act);
    if (act !== exp) begin
      $display("Mismatch at %0t: fc_limits_o expected %h got %h", $time, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_outputs();
    check_limits(m_lim, fc_limits_o);
    check_bit("fc1_done_o", &m_fc1, fc1_done_o);
    check_bit("fc2_done_o", &m_fc2, fc2_done_o);
    check_seq("next_seq_o", m_next, next_seq_o);
    check_seq("ackd_seq_o", m_ackd, ackd_seq_o);
    check_seq("outstanding_o", m_next - 12'd1 - m_ackd, outstanding_o);
    check_bit("nak_replay_o", m_nak, nak_replay_o);
  endtask

  // serial crc msb first and inverted at the end
  function automatic logic [15:0] ref_crc(input logic [31:0] body);
    logic [15:0] r;
    logic msb;
    r = 16'hFFFF;
    for (int i = 31; i >= 0; i--) begin
      msb = r[15];
      r = r << 1;
      if (msb ^ body[i]) r = r ^ 16'h100B;
    end
    return ~r;
  endfunction

  function automatic logic [31:0] fc_body(input logic [7:0] t, input logic [7:0] h,
                                          input logic [11:0] d);
    return {t, 2'b00, h, 2'b00, d};
  endfunction

  function automatic logic [31:0] seq_body(input logic [7:0] t, input logic [11:0] s);
    return {t, 12'h000, s};
  endfunction

  function automatic logic credit_ok(input fc_req_t req);
    logic [7:0] h;
    logic [11:0] d;
    if (req.posted) begin
      h = m_lim.ph - m_ph - 8'd1;
      d = m_lim.pd - m_pd - req.data_cred;
    end else begin
      h = m_lim.nph - m_nph - 8'd1;
      d = m_lim.npd - m_npd - req.data_cred;
    end
    return req.vld && (&m_fc2) && (h <= 8'd128) && (d <= 12'd2048);
  endfunction

  task automatic apply_dllp(input logic [31:0] body);
    logic [7:0] t;
    t = body[31:24] & 8'hF8;
    if (t == ACK || t == NAK) begin
      m_ackd = body[11:0];
      m_nak = (t == NAK);
    end
    if (t == INITFC1_P || t == INITFC2_P || t == UPDATEFC_P) begin
      m_lim.ph = body[21:14];
      m_lim.pd = body[11:0];
    end
    if (t == INITFC1_NP || t == INITFC2_NP || t == UPDATEFC_NP) begin
      m_lim.nph = body[21:14];
      m_lim.npd = body[11:0];
    end
    if (t == INITFC1_P) m_fc1[0] = 1'b1;
    if (t == INITFC1_NP) m_fc1[1] = 1'b1;
    if (t == INITFC1_CPL) m_fc1[2] = 1'b1;
    if (t == INITFC2_P) m_fc2[0] = 1'b1;
    if (t == INITFC2_NP) m_fc2[1] = 1'b1;
    if (t == INITFC2_CPL) m_fc2[2] = 1'b1;
  endtask

  task automatic wait_ready();
    do @(negedge clk_i); while (rx_ready_o !== 1'b1);
  endtask

  task automatic send_dllp(input entry_t e);
    logic [15:0] crc;
    int gap;
    crc = ref_crc(e.body);
    if (e.corrupt) crc = crc ^ 16'h8001;
    gap = $urandom % 4;
    @(posedge clk_i);
    repeat (gap) @(posedge clk_i);
    rx_i <= {e.body, 1'b1};
    wait_ready();
    @(posedge clk_i);
    gap = $urandom % 4;
    if (gap > 0) begin
      rx_i.tvalid <= 1'b0;
      repeat (gap) @(posedge clk_i);
    end
    rx_i <= {16'h0000, crc, 1'b1};
    wait_ready();
    check_bit("crc_err_o", e.exp, crc_err_o);
    @(posedge clk_i);
    rx_i <= '0;
    // nothing visible yet in the PROCESS cycle
    @(negedge clk_i);
    check_outputs();
    if (!e.corrupt) apply_dllp(e.body);
    @(negedge clk_i);
    check_outputs();
    m_nak = 1'b0;
    @(negedge clk_i);
    check_bit("nak_replay_o", 1'b0, nak_replay_o);
  endtask

  task automatic add_entry(input op_e op, input logic [31:0] body, input logic corrupt,
                           input fc_req_t req, input logic exp);
    tbl.push_back({op, body, corrupt, req, exp});
  endtask

  task automatic build_table();
    add_entry(OP_LINK, fc_body(INITFC1_P, 8'd7, 12'd7), 1'b0, '0, 1'b0);
    add_entry(OP_REQ, '0, 1'b0, {1'b1, 1'b1, 12'd2}, 1'b0);
    add_entry(OP_DLLP, fc_body(INITFC1_P, 8'd2, 12'd8), 1'b0, '0, 1'b0);
    add_entry(OP_DLLP, fc_body(INITFC1_NP, 8'd1, 12'd4), 1'b0, '0, 1'b0);
    add_entry(OP_DLLP, fc_body(INITFC1_CPL, 8'd0, 12'd0), 1'b0, '0, 1'b0);
    add_entry(OP_DLLP, fc_body(INITFC2_P, 8'd9, 12'd99), 1'b1, '0, 1'b1);
    add_entry(OP_DLLP, fc_body(INITFC2_P, 8'd2, 12'd8), 1'b0, '0, 1'b0);
    add_entry(OP_DLLP, fc_body(INITFC2_NP, 8'd1, 12'd4), 1'b0, '0, 1'b0);
    add_entry(OP_REQ, '0, 1'b0, {1'b1, 1'b1, 12'd1}, 1'b0);
    // VC bits set but still decoded
    add_entry(OP_DLLP, fc_body(8'hE2, 8'd0, 12'd0), 1'b0, '0, 1'b0);
    add_entry(OP_REQ, '0, 1'b0, {1'b1, 1'b1, 12'd3}, 1'b1);
    add_entry(OP_REQ, '0, 1'b0, {1'b1, 1'b1, 12'd5}, 1'b1);
    add_entry(OP_REQ, '0, 1'b0, {1'b1, 1'b1, 12'd0}, 1'b0);
    add_entry(OP_REQ, '0, 1'b0, {1'b1, 1'b0, 12'd5}, 1'b0);
    add_entry(OP_REQ, '0, 1'b0, {1'b1, 1'b0, 12'd4}, 1'b1);
    add_entry(OP_DLLP, fc_body(UPDATEFC_P, 8'd3, 12'd10), 1'b0, '0, 1'b0);
    add_entry(OP_REQ, '0, 1'b0, {1'b1, 1'b1, 12'd2}, 1'b1);
    repeat (4) add_entry(OP_SENT, '0, 1'b0, '0, 1'b0);
    add_entry(OP_DLLP, seq_body(ACK, 12'd1), 1'b0, '0, 1'b0);
    add_entry(OP_DLLP, seq_body(NAK, 12'd2), 1'b0, '0, 1'b0);
    add_entry(OP_DLLP, seq_body(ACK, 12'd3), 1'b1, '0, 1'b1);
    add_entry(OP_DLLP, seq_body(8'h05, 12'd3), 1'b0, '0, 1'b0);
    // power management and completion update are ignored
    add_entry(OP_DLLP, seq_body(8'h20, 12'd9), 1'b0, '0, 1'b0);
    add_entry(OP_DLLP, fc_body(UPDATEFC_CPL, 8'd5, 12'd5), 1'b0, '0, 1'b0);
  endtask

  initial begin
    rst_i = 1'b1;
    phy_link_up_i = 1'b1;
    rx_i = '0;
    tlp_sent_i = 1'b0;
    fc_req_i = '0;
    seed = $urandom(32'hba793051);
    build_table();
    cycle_limit = 10 * tbl.size() + 100;
    m_lim = '0;
    m_fc1 = '0;
    m_fc2 = '0;
    m_next = '0;
    m_ackd = 12'hFFF;
    {m_ph, m_nph, m_pd, m_npd} = '0;
    m_nak = 1'b0;
    @(negedge clk_i);
    check_bit("rx_ready_o", 1'b0, rx_ready_o);
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    check_outputs();
    foreach (tbl[i]) begin
      case (tbl[i].op)
        OP_DLLP: send_dllp(tbl[i]);
        OP_SENT: begin
          @(posedge clk_i);
          tlp_sent_i <= 1'b1;
          @(posedge clk_i);
          tlp_sent_i <= 1'b0;
          m_next = m_next + 12'd1;
          @(negedge clk_i);
          check_outputs();
        end
        OP_REQ: begin
          @(posedge clk_i);
          fc_req_i <= tbl[i].req;
          @(negedge clk_i);
          if (credit_ok(tbl[i].req) !== tbl[i].exp) begin
            $display("table entry %0d disagrees with the credit model", i);
            abort_run();
          end
          check_bit("fc_grant_o", tbl[i].exp, fc_grant_o);
          if (tbl[i].exp && tbl[i].req.posted) begin
            m_ph = m_ph + 8'd1;
            m_pd = m_pd + tbl[i].req.data_cred;
          end else if (tbl[i].exp) begin
            m_nph = m_nph + 8'd1;
            m_npd = m_npd + tbl[i].req.data_cred;
          end
          @(posedge clk_i);
          fc_req_i <= '0;
        end
        default: begin
          @(posedge clk_i);
          phy_link_up_i <= 1'b0;
          rx_i <= {tbl[i].body, 1'b1};
          repeat (4) begin
            @(negedge clk_i);
            check_bit("rx_ready_o", 1'b0, rx_ready_o);
          end
          @(posedge clk_i);
          rx_i <= '0;
          phy_link_up_i <= 1'b1;
          @(negedge clk_i);
          check_outputs();
        end
      endcase
    end
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
design/pcie_dll_pkg.sv
design/dllp_crc16.sv
design/dllp_rx_handler.sv
design/replay_seq_tracker.sv
design/fc_credit_gate.sv
design/dll_rx_top.sv
dv/dll_rx_tb.sv
